/* sim_mem.f */
src/sim_mem_pkg.sv
src/axi_ram.sv
src/mmio_intercept.sv
src/console_buffer.sv
src/sim_mem_top.sv
tests/tb_sim_mem.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sim_mem \
  -f sim_mem.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit "$status"
fi

./obj_dir/Vtb_sim_mem
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation returned status $status"
  exit "$status"
fi

exit 0

/* tests/tb_sim_mem.sv */
module tb_sim_mem;
  timeunit 1ns;
  timeprecision 1ps;

  logic                           clk;
  logic                           rst;
  logic [sim_mem_pkg::addr_w-1:0] awaddr;
  logic                           awvalid;
  logic                           awready;
  logic [sim_mem_pkg::data_w-1:0] wdata;
  logic [sim_mem_pkg::strb_w-1:0] wstrb;
  logic                           wvalid;
  logic                           wready;
  logic [1:0]                     bresp;
  logic                           bvalid;
  logic                           bready;
  logic [sim_mem_pkg::addr_w-1:0] araddr;
  logic                           arvalid;
  logic                           arready;
  logic [sim_mem_pkg::data_w-1:0] rdata;
  logic [1:0]                     rresp;
  logic                           rvalid;
  logic                           rready;
  logic [7:0]                     csr;
  logic                           console_valid;
  logic [7:0]                     console_data;
  logic                           console_ready;

  logic [15:0]                    lfsr_q;
  logic [15:0]                    con_lfsr_q;
  logic                           hold_console;
  logic [sim_mem_pkg::data_w-1:0] ram_model [sim_mem_pkg::mem_words];
  logic [sim_mem_pkg::strb_w-1:0] known [sim_mem_pkg::mem_words];
  logic [7:0]                     csr_model;
  logic [7:0]                     con_q [$];

  sim_mem_top u_sim_mem_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per returned bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] ram_addr(input int idx);
    return 32'(idx) << 2;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stop_run($sformatf("Fail: time %0t signal %s expected %h actual %h",
                         $time, name, exp, act));
    end
  endtask

  function automatic logic ready_of(input string name);
    if (name == "awready") begin
      return awready;
    end else if (name == "wready") begin
      return wready;
    end
    return arready;
  endfunction

  // returns just after a falling edge with the ready high, so the beat moves on the next edge.
  task automatic await_ready(input string name);
    int n;
    n = 0;
    #1;
    while (!ready_of(name)) begin
      n++;
      if (n > 200) begin
        stop_run($sformatf("timed out waiting for %s", name));
      end
      @(negedge clk);
      #1;
    end
  endtask

  task automatic write_beat(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic expect_full);
    int idx;
    int n;
    idx = int'(addr[sim_mem_pkg::ram_aw+1:2]);
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    await_ready("awready");
    @(negedge clk);
    awvalid = 1'b0;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    if (expect_full) begin
      for (n = 0; n < 4; n++) begin
        #1;
        check_value("wready", 0, wready);
        @(negedge clk);
      end
      #1;
      hold_console = 1'b0;
    end
    await_ready("wready");
    check_value("bvalid", 0, bvalid);
    check_value("csr", csr_model, csr);
    if (addr == sim_mem_pkg::csr_addr) begin
      csr_model = data[7:0];
    end else if (addr == sim_mem_pkg::console_addr) begin
      con_q.push_back(data[7:0]);
    end else begin
      for (int b = 0; b < sim_mem_pkg::strb_w; b++) begin
        if (strb[b]) begin
          ram_model[idx][8*b +: 8] = data[8*b +: 8];
          known[idx][b] = 1'b1;
        end
      end
    end
    @(negedge clk);
    wvalid = 1'b0;
    check_value("bvalid", 1, bvalid);
    check_value("bresp", sim_mem_pkg::resp_okay, bresp);
    check_value("csr", csr_model, csr);
    n = int'(rand_bits(2));
    repeat (n) begin
      @(negedge clk);
      check_value("bvalid", 1, bvalid);
      check_value("bresp", sim_mem_pkg::resp_okay, bresp);
      check_value("awready", 0, awready);
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    check_value("bvalid", 0, bvalid);
  endtask

  task automatic read_beat(input logic [31:0] addr);
    int idx;
    int n;
    logic [31:0] exp;
    logic [31:0] mask;
    logic [31:0] first;
    idx  = int'(addr[sim_mem_pkg::ram_aw+1:2]);
    mask = '1;
    if (addr == sim_mem_pkg::csr_addr) begin
      exp = 32'(csr_model);
    end else if (addr == sim_mem_pkg::console_addr) begin
      exp = '0;
    end else begin
      exp  = ram_model[idx];
      mask = '0;
      for (int b = 0; b < sim_mem_pkg::strb_w; b++) begin
        if (known[idx][b]) begin
          mask[8*b +: 8] = 8'hff;
        end
      end
    end
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    await_ready("arready");
    check_value("rvalid", 0, rvalid);
    @(negedge clk);
    arvalid = 1'b0;
    check_value("rvalid", 1, rvalid);
    check_value("rresp", sim_mem_pkg::resp_okay, rresp);
    check_value("rdata", exp & mask, rdata & mask);
    first = rdata;
    n = int'(rand_bits(2));
    repeat (n) begin
      @(negedge clk);
      check_value("rvalid", 1, rvalid);
      check_value("rdata", first, rdata);
      check_value("arready", 0, arready);
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check_value("rvalid", 0, rvalid);
  endtask

  task automatic drain_console();
    int n;
    n = 0;
    @(negedge clk);
    #3;
    while (con_q.size() != 0 || console_valid) begin
      n++;
      if (n > 200) begin
        stop_run("console bytes did not drain in time");
      end
      @(negedge clk);
      #3;
    end
  endtask

  // console sink with random stalls; each byte is compared with the model queue as it leaves.
  initial begin
    logic [7:0] exp_byte;
    logic [7:0] held_byte;
    logic       stalled;
    console_ready = 1'b0;
    con_lfsr_q    = 16'd7318;
    stalled       = 1'b0;
    held_byte     = '0;
    forever begin
      @(negedge clk);
      con_lfsr_q    = lfsr_step(con_lfsr_q);
      console_ready = rst && !hold_console && con_lfsr_q[0];
      #2;
      if (console_valid && stalled) begin
        check_value("console_data", held_byte, console_data);
      end
      if (console_valid && console_ready) begin
        if (con_q.size() == 0) begin
          stop_run("console produced a byte that was never written");
        end
        exp_byte = con_q.pop_front();
        check_value("console_data", exp_byte, console_data);
        stalled = 1'b0;
      end else if (console_valid) begin
        stalled   = 1'b1;
        held_byte = console_data;
      end
    end
  end

  initial begin
    int sel;
    int idx;
    int last_idx;
    rst          = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    hold_console = 1'b0;
    lfsr_q       = 16'd7318;
    csr_model    = '0;
    last_idx     = 0;
    for (int i = 0; i < sim_mem_pkg::mem_words; i++) begin
      known[i] = '0;
    end

    repeat (5) @(negedge clk);
    check_value("awready", 0, awready);
    check_value("arready", 0, arready);
    check_value("wready", 0, wready);
    check_value("bvalid", 0, bvalid);
    check_value("rvalid", 0, rvalid);
    check_value("console_valid", 0, console_valid);
    check_value("csr", 0, csr);
    rst = 1'b1;
    @(negedge clk);
    check_value("awready", 1, awready);
    check_value("arready", 1, arready);
    check_value("wready", 0, wready);

    // the RAM words behind the two register addresses must not change.
    write_beat(ram_addr(512), rand_bits(32), 4'hf, 1'b0);
    write_beat(ram_addr(768), rand_bits(32), 4'hf, 1'b0);
    write_beat(sim_mem_pkg::csr_addr, rand_bits(32), 4'hf, 1'b0);
    write_beat(sim_mem_pkg::console_addr, rand_bits(32), 4'hf, 1'b0);
    read_beat(sim_mem_pkg::csr_addr);
    read_beat(sim_mem_pkg::console_addr);
    read_beat(ram_addr(512));
    read_beat(ram_addr(768));

    drain_console();
    hold_console = 1'b1;
    repeat (sim_mem_pkg::console_depth) begin
      write_beat(sim_mem_pkg::console_addr, rand_bits(32), 4'hf, 1'b0);
    end
    write_beat(sim_mem_pkg::console_addr, rand_bits(32), 4'hf, 1'b1);
    write_beat(sim_mem_pkg::console_addr, rand_bits(32), 4'hf, 1'b0);

    for (int op = 0; op < 300; op++) begin
      sel = int'(rand_bits(3));
      if (sel < 5) begin
        if (rand_bits(1) == 1) begin
          idx      = int'(rand_bits(sim_mem_pkg::ram_aw));
          last_idx = idx;
          write_beat(ram_addr(idx), rand_bits(32), 4'(rand_bits(4)), 1'b0);
        end else begin
          idx = (rand_bits(1) == 1) ? last_idx : int'(rand_bits(sim_mem_pkg::ram_aw));
          read_beat(ram_addr(idx));
        end
      end else if (sel == 5) begin
        if (rand_bits(1) == 1) begin
          write_beat(sim_mem_pkg::csr_addr, rand_bits(32), 4'(rand_bits(4)), 1'b0);
        end else begin
          read_beat(sim_mem_pkg::csr_addr);
        end
      end else begin
        if (rand_bits(1) == 1) begin
          write_beat(sim_mem_pkg::console_addr, rand_bits(32), 4'hf, 1'b0);
        end else begin
          read_beat(sim_mem_pkg::console_addr);
        end
      end
    end

    drain_console();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* src/sim_mem_top.sv */
module sim_mem_top (
  input  logic                            clk,
  input  logic                            rst,

  input  logic [sim_mem_pkg::addr_w-1:0]  awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [sim_mem_pkg::data_w-1:0]  wdata,
  input  logic [sim_mem_pkg::strb_w-1:0]  wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [sim_mem_pkg::addr_w-1:0]  araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [sim_mem_pkg::data_w-1:0]  rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,

  output logic [7:0]                      csr,

  output logic                            console_valid,
  output logic [7:0]                      console_data,
  input  logic                            console_ready
);

  logic [sim_mem_pkg::addr_w-1:0] ram_awaddr;
  logic                           ram_awvalid;
  logic                           ram_awready;
  logic [sim_mem_pkg::data_w-1:0] ram_wdata;
  logic [sim_mem_pkg::strb_w-1:0] ram_wstrb;
  logic                           ram_wvalid;
  logic                           ram_wready;
  logic [1:0]                     ram_bresp;
  logic                           ram_bvalid;
  logic                           ram_bready;
  logic [sim_mem_pkg::addr_w-1:0] ram_araddr;
  logic                           ram_arvalid;
  logic                           ram_arready;
  logic [sim_mem_pkg::data_w-1:0] ram_rdata;
  logic [1:0]                     ram_rresp;
  logic                           ram_rvalid;
  logic                           ram_rready;

  logic       push;
  logic [7:0] push_data;
  logic       full;

  // port names match the local nets one to one.
  mmio_intercept u_intercept (.*);

  axi_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (ram_awaddr),
    .awvalid (ram_awvalid),
    .awready (ram_awready),
    .wdata   (ram_wdata),
    .wstrb   (ram_wstrb),
    .wvalid  (ram_wvalid),
    .wready  (ram_wready),
    .bresp   (ram_bresp),
    .bvalid  (ram_bvalid),
    .bready  (ram_bready),
    .araddr  (ram_araddr),
    .arvalid (ram_arvalid),
    .arready (ram_arready),
    .rdata   (ram_rdata),
    .rresp   (ram_rresp),
    .rvalid  (ram_rvalid),
    .rready  (ram_rready)
  );

  console_buffer u_console (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_data     (push_data),
    .full          (full),
    .console_valid (console_valid),
    .console_data  (console_data),
    .console_ready (console_ready)
  );

endmodule

/* src/console_buffer.sv */
module console_buffer (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  logic [7:0] push_data,
  output logic       full,
  output logic       console_valid,
  output logic [7:0] console_data,
  input  logic       console_ready
);

  logic [7:0] fifo [sim_mem_pkg::console_depth];

  logic [$clog2(sim_mem_pkg::console_depth)-1:0] wr_ptr_q;
  logic [$clog2(sim_mem_pkg::console_depth)-1:0] rd_ptr_q;
  logic [$clog2(sim_mem_pkg::console_depth):0]   count_q;

  logic pop;
  logic do_push;

  assign full          = count_q == sim_mem_pkg::console_depth;
  assign console_valid = count_q != 0;
  assign console_data  = fifo[rd_ptr_q];

  // a full buffer still takes a byte when one leaves on the same edge.
  assign pop     = console_valid && console_ready;
  assign do_push = push && (!full || pop);

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == sim_mem_pkg::console_depth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == sim_mem_pkg::console_depth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      fifo[wr_ptr_q] <= push_data;
    end
  end

endmodule

/* src/mmio_intercept.sv */
module mmio_intercept (
  input  logic                            clk,
  input  logic                            rst,

  input  logic [sim_mem_pkg::addr_w-1:0]  awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [sim_mem_pkg::data_w-1:0]  wdata,
  input  logic [sim_mem_pkg::strb_w-1:0]  wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [sim_mem_pkg::addr_w-1:0]  araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [sim_mem_pkg::data_w-1:0]  rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,

  output logic [sim_mem_pkg::addr_w-1:0]  ram_awaddr,
  output logic                            ram_awvalid,
  input  logic                            ram_awready,
  output logic [sim_mem_pkg::data_w-1:0]  ram_wdata,
  output logic [sim_mem_pkg::strb_w-1:0]  ram_wstrb,
  output logic                            ram_wvalid,
  input  logic                            ram_wready,
  input  logic [1:0]                      ram_bresp,
  input  logic                            ram_bvalid,
  output logic                            ram_bready,
  output logic [sim_mem_pkg::addr_w-1:0]  ram_araddr,
  output logic                            ram_arvalid,
  input  logic                            ram_arready,
  input  logic [sim_mem_pkg::data_w-1:0]  ram_rdata,
  input  logic [1:0]                      ram_rresp,
  input  logic                            ram_rvalid,
  output logic                            ram_rready,

  output logic                            push,
  output logic [7:0]                      push_data,
  input  logic                            full,

  output logic [7:0]                      csr
);

  logic aw_csr_hit;
  logic aw_con_hit;
  logic aw_ram_hit;
  logic ar_csr_hit;
  logic ar_con_hit;
  logic ar_ram_hit;

  logic awready_q;
  logic wr_busy_q;
  logic wr_csr_q;
  logic wr_con_q;
  logic wr_ram_q;
  logic loc_bvalid_q;
  logic [7:0] csr_q;

  logic arready_q;
  logic rd_busy_q;
  logic rd_ram_q;
  logic loc_rvalid_q;
  logic [sim_mem_pkg::data_w-1:0] loc_rdata_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;
  logic wr_busy_d;
  logic rd_busy_d;

  assign aw_csr_hit = awaddr == sim_mem_pkg::csr_addr;
  assign aw_con_hit = awaddr == sim_mem_pkg::console_addr;
  assign aw_ram_hit = !aw_csr_hit && !aw_con_hit;
  assign ar_csr_hit = araddr == sim_mem_pkg::csr_addr;
  assign ar_con_hit = araddr == sim_mem_pkg::console_addr;
  assign ar_ram_hit = !ar_csr_hit && !ar_con_hit;

  // write address: RAM accesses pass straight through while no write is pending.
  assign ram_awaddr  = awaddr;
  assign ram_awvalid = awvalid && awready_q && aw_ram_hit;
  assign awready     = awready_q && (ram_awready || !aw_ram_hit);
  assign aw_fire     = awvalid && awready;

  assign ram_wdata  = wdata;
  assign ram_wstrb  = wstrb;
  assign ram_wvalid = wvalid && wr_busy_q && wr_ram_q;

  // a console write stalls here until the buffer has room.
  always_comb begin
    if (!wr_busy_q) begin
      wready = 1'b0;
    end else if (wr_ram_q) begin
      wready = ram_wready;
    end else if (wr_con_q) begin
      wready = !loc_bvalid_q && !full;
    end else begin
      wready = !loc_bvalid_q;
    end
  end

  assign w_fire    = wvalid && wready;
  assign push      = w_fire && wr_con_q;
  assign push_data = wdata[7:0];

  assign bvalid     = wr_busy_q && (wr_ram_q ? ram_bvalid : loc_bvalid_q);
  assign bresp      = wr_ram_q ? ram_bresp : sim_mem_pkg::resp_okay;
  assign ram_bready = bready && wr_busy_q && wr_ram_q;
  assign b_fire     = bvalid && bready;

  assign wr_busy_d = aw_fire || (wr_busy_q && !b_fire);

  always_ff @(posedge clk) begin
    if (!rst) begin
      awready_q    <= 1'b0;
      wr_busy_q    <= 1'b0;
      wr_csr_q     <= 1'b0;
      wr_con_q     <= 1'b0;
      wr_ram_q     <= 1'b0;
      loc_bvalid_q <= 1'b0;
      csr_q        <= 8'h00;
    end else begin
      awready_q <= !wr_busy_d;
      wr_busy_q <= wr_busy_d;
      if (aw_fire) begin
        wr_csr_q <= aw_csr_hit;
        wr_con_q <= aw_con_hit;
        wr_ram_q <= aw_ram_hit;
      end
      if (w_fire && !wr_ram_q) begin
        loc_bvalid_q <= 1'b1;
      end else if (b_fire) begin
        loc_bvalid_q <= 1'b0;
      end
      if (w_fire && wr_csr_q) begin
        csr_q <= wdata[7:0];
      end
    end
  end

  assign csr = csr_q;

  // read side mirrors the write side with a single target flag.
  assign ram_araddr  = araddr;
  assign ram_arvalid = arvalid && arready_q && ar_ram_hit;
  assign arready     = arready_q && (ram_arready || !ar_ram_hit);
  assign ar_fire     = arvalid && arready;

  assign rvalid     = rd_busy_q && (rd_ram_q ? ram_rvalid : loc_rvalid_q);
  assign rdata      = rd_ram_q ? ram_rdata : loc_rdata_q;
  assign rresp      = rd_ram_q ? ram_rresp : sim_mem_pkg::resp_okay;
  assign ram_rready = rready && rd_busy_q && rd_ram_q;
  assign r_fire     = rvalid && rready;

  assign rd_busy_d = ar_fire || (rd_busy_q && !r_fire);

  always_ff @(posedge clk) begin
    if (!rst) begin
      arready_q    <= 1'b0;
      rd_busy_q    <= 1'b0;
      rd_ram_q     <= 1'b0;
      loc_rvalid_q <= 1'b0;
    end else begin
      arready_q <= !rd_busy_d;
      rd_busy_q <= rd_busy_d;
      if (ar_fire) begin
        rd_ram_q <= ar_ram_hit;
      end
      if (ar_fire && !ar_ram_hit) begin
        loc_rvalid_q <= 1'b1;
      end else if (r_fire) begin
        loc_rvalid_q <= 1'b0;
      end
    end
  end

  // the console port reads back as zero.
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      loc_rdata_q <= ar_csr_hit ? {{(sim_mem_pkg::data_w-8){1'b0}}, csr_q} : '0;
    end
  end

endmodule

/* src/axi_ram.sv */
module axi_ram (
  input  logic                            clk,
  input  logic                            rst,

  input  logic [sim_mem_pkg::addr_w-1:0]  awaddr,
  input  logic                            awvalid,
  output logic                            awready,

  input  logic [sim_mem_pkg::data_w-1:0]  wdata,
  input  logic [sim_mem_pkg::strb_w-1:0]  wstrb,
  input  logic                            wvalid,
  output logic                            wready,

  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,

  input  logic [sim_mem_pkg::addr_w-1:0]  araddr,
  input  logic                            arvalid,
  output logic                            arready,

  output logic [sim_mem_pkg::data_w-1:0]  rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready
);

  logic [sim_mem_pkg::data_w-1:0] mem [sim_mem_pkg::mem_words];

  logic                           aw_have_q;
  logic [sim_mem_pkg::ram_aw-1:0] aw_idx_q;
  logic                           w_have_q;
  logic [sim_mem_pkg::data_w-1:0] wdata_q;
  logic [sim_mem_pkg::strb_w-1:0] wstrb_q;
  logic                           bvalid_q;

  logic                           rvalid_q;
  logic [sim_mem_pkg::data_w-1:0] rdata_q;

  logic                           aw_fire;
  logic                           w_fire;
  logic                           do_write;
  logic [sim_mem_pkg::ram_aw-1:0] wr_idx;
  logic [sim_mem_pkg::data_w-1:0] wr_data;
  logic [sim_mem_pkg::strb_w-1:0] wr_strb;
  logic                           ar_fire;

  // each write channel takes one beat, then waits for the other and the response.
  assign awready = !aw_have_q && !bvalid_q;
  assign wready  = !w_have_q && !bvalid_q;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  // the word is written on the edge where the later of the two beats arrives.
  assign do_write = (aw_have_q || aw_fire) && (w_have_q || w_fire);
  assign wr_idx   = aw_have_q ? aw_idx_q : awaddr[sim_mem_pkg::ram_aw+1:2];
  assign wr_data  = w_have_q ? wdata_q : wdata;
  assign wr_strb  = w_have_q ? wstrb_q : wstrb;

  assign bvalid = bvalid_q;
  assign bresp  = sim_mem_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (!rst) begin
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      bvalid_q  <= 1'b0;
    end else begin
      if (do_write) begin
        aw_have_q <= 1'b0;
        w_have_q  <= 1'b0;
        bvalid_q  <= 1'b1;
      end else begin
        if (aw_fire) begin
          aw_have_q <= 1'b1;
        end
        if (w_fire) begin
          w_have_q <= 1'b1;
        end
        if (bvalid_q && bready) begin
          bvalid_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_idx_q <= awaddr[sim_mem_pkg::ram_aw+1:2];
    end
    if (w_fire) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int b = 0; b < sim_mem_pkg::strb_w; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // read side: one outstanding beat, data captured when the address is taken.
  assign arready = !rvalid_q;
  assign ar_fire = arvalid && arready;

  assign rvalid = rvalid_q;
  assign rdata  = rdata_q;
  assign rresp  = sim_mem_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rvalid_q <= 1'b0;
    end else if (ar_fire) begin
      rvalid_q <= 1'b1;
    end else if (rvalid_q && rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata_q <= mem[araddr[sim_mem_pkg::ram_aw+1:2]];
    end
  end

endmodule

/* src/sim_mem_pkg.sv */
package sim_mem_pkg;

  // AXI port widths.
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned strb_w = data_w / 8;

  // RAM size; only the low address bits above the byte offset index a word.
  localparam int unsigned mem_kb    = 4;
  localparam int unsigned mem_words = (mem_kb * 1024) / strb_w;
  localparam int unsigned ram_aw    = $clog2(mem_words);

  // memory-mapped registers claimed by the intercept.
  localparam logic [addr_w-1:0] csr_addr     = 32'hA001_FC00;
  localparam logic [addr_w-1:0] console_addr = 32'hA001_F800;

  localparam logic [1:0] resp_okay = 2'b00;

  localparam int unsigned console_depth = 4;

endpackage
